/* sw_pkg.sv */
// smith-waterman core definitions
package sw_pkg;

    // array sizing
    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 8;   // one cell per read base

    localparam int SCORE_W    = 10;
    localparam int REF_LEN_W  = $clog2(REF_MAX_LEN) + 1;
    localparam int READ_LEN_W = $clog2(READ_MAX_LEN) + 1;
    localparam int COL_W      = $clog2(REF_MAX_LEN);
    localparam int ROW_W      = $clog2(READ_MAX_LEN);
    localparam int STEP_W     = $clog2(REF_MAX_LEN + READ_MAX_LEN + 1);

    // affine scoring
    localparam logic signed [SCORE_W-1:0] MATCH_SCORE    = 2;
    localparam logic signed [SCORE_W-1:0] MISMATCH_SCORE = -1;
    localparam logic signed [SCORE_W-1:0] GAP_OPEN       = -2;
    localparam logic signed [SCORE_W-1:0] GAP_EXTEND     = -1;

    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_C = 2'd1,
        BASE_G = 2'd2,
        BASE_T = 2'd3
    } base_t;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        LOAD = 3'd1,
        CALC = 3'd2,
        SCAN = 3'd3,
        DONE = 3'd4
    } sw_state_t;

endpackage

/* sw_pe.sv */
`timescale 1ns/100ps
// systolic alignment cell
module sw_pe import sw_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_calc_en,
    input  logic                      i_ref_base_valid,
    input  base_t                     i_ref_base,
    input  base_t                     i_read_base,
    input  logic signed [SCORE_W-1:0] i_diag_align,
    input  logic signed [SCORE_W-1:0] i_diag_insert,
    input  logic signed [SCORE_W-1:0] i_diag_delete,
    input  logic signed [SCORE_W-1:0] i_top_align,
    input  logic signed [SCORE_W-1:0] i_top_insert,
    input  logic signed [SCORE_W-1:0] i_left_align,
    input  logic signed [SCORE_W-1:0] i_left_insert,
    input  logic signed [SCORE_W-1:0] i_left_delete,
    output logic signed [SCORE_W-1:0] o_align,
    output logic signed [SCORE_W-1:0] o_insert,
    output logic signed [SCORE_W-1:0] o_delete,
    output logic signed [SCORE_W-1:0] o_score,
    output logic                      o_ref_base_valid,
    output base_t                     o_ref_base
);
    logic                      active;
    logic signed [SCORE_W-1:0] weight;
    logic signed [SCORE_W-1:0] cell_h;

    function automatic logic signed [SCORE_W-1:0] smax(
        input logic signed [SCORE_W-1:0] a,
        input logic signed [SCORE_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    assign active = i_calc_en && i_ref_base_valid;
    assign weight = (i_ref_base == i_read_base) ? MATCH_SCORE : MISMATCH_SCORE;

    always_comb begin
        if (active) begin
            o_align  = smax('0, weight + smax(i_diag_align, smax(i_diag_insert, i_diag_delete)));
            o_insert = smax('0, smax(i_top_align + GAP_OPEN, i_top_insert + GAP_EXTEND));
            o_delete = smax('0, smax(i_left_align + GAP_OPEN, i_left_delete + GAP_EXTEND));
        end else begin
            // no reference base here yet, carry the left cell
            o_align  = i_left_align;
            o_insert = i_left_insert;
            o_delete = i_left_delete;
        end
        cell_h = smax(smax('0, o_align), smax(o_insert, o_delete));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_score          <= '0;
            o_ref_base_valid <= 1'b0;
            o_ref_base       <= BASE_A;
        end else begin
            o_score          <= i_calc_en ? cell_h : '0;  // zero outside calc
            o_ref_base_valid <= active;
            o_ref_base       <= i_ref_base;               // on to next row
        end
    end

endmodule

/* sw_pe_array.sv */
`timescale 1ns/100ps
// systolic cell array
module sw_pe_array import sw_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_load,
    input  logic                            i_calc_en,
    input  logic [2*REF_MAX_LEN-1:0]        i_seq_ref,
    input  logic [2*READ_MAX_LEN-1:0]       i_seq_read,
    input  logic                            i_ref_base_valid,
    output logic [READ_MAX_LEN*SCORE_W-1:0] o_row_scores
);
    logic [2*REF_MAX_LEN-1:0]  ref_shift;
    logic [2*READ_MAX_LEN-1:0] read_seq;

    // {align, insert, delete} per row
    logic [3*SCORE_W-1:0] cell_c  [READ_MAX_LEN];
    logic [3*SCORE_W-1:0] cell_d  [READ_MAX_LEN];  // one step back
    logic [3*SCORE_W-1:0] cell_dd [READ_MAX_LEN];  // two steps back

    logic  base_valid [READ_MAX_LEN+1];
    base_t base       [READ_MAX_LEN+1];

    assign base_valid[0] = i_ref_base_valid;
    assign base[0]       = base_t'(ref_shift[2*REF_MAX_LEN-1 -: 2]);

    always_ff @(posedge clk) begin
        if (i_load) begin
            ref_shift <= i_seq_ref;
            read_seq  <= i_seq_read;
        end else if (i_calc_en) begin
            ref_shift <= ref_shift << 2;  // next base into row 0
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cell_d  <= '{default: '0};
            cell_dd <= '{default: '0};
        end else if (i_load) begin
            cell_d  <= '{default: '0};
            cell_dd <= '{default: '0};
        end else if (i_calc_en) begin
            cell_d  <= cell_c;
            cell_dd <= cell_d;
        end
    end

    for (genvar r = 0; r < READ_MAX_LEN; r++) begin : g_row
        logic [3*SCORE_W-1:0]      top;
        logic [3*SCORE_W-1:0]      diag;
        logic signed [SCORE_W-1:0] align;
        logic signed [SCORE_W-1:0] insert;
        logic signed [SCORE_W-1:0] delete;
        logic signed [SCORE_W-1:0] score;

        if (r == 0) begin : g_edge
            assign top  = '0;  // matrix border
            assign diag = '0;
        end else begin : g_inner
            assign top  = cell_d[r-1];
            assign diag = cell_dd[r-1];
        end

        sw_pe u_pe (
            .clk              (clk),
            .rst              (rst),
            .i_calc_en        (i_calc_en),
            .i_ref_base_valid (base_valid[r]),
            .i_ref_base       (base[r]),
            .i_read_base      (base_t'(read_seq[2*READ_MAX_LEN-1-2*r -: 2])),
            .i_diag_align     (diag[3*SCORE_W-1 -: SCORE_W]),
            .i_diag_insert    (diag[2*SCORE_W-1 -: SCORE_W]),
            .i_diag_delete    (diag[SCORE_W-1:0]),
            .i_top_align      (top[3*SCORE_W-1 -: SCORE_W]),
            .i_top_insert     (top[2*SCORE_W-1 -: SCORE_W]),
            .i_left_align     (cell_d[r][3*SCORE_W-1 -: SCORE_W]),
            .i_left_insert    (cell_d[r][2*SCORE_W-1 -: SCORE_W]),
            .i_left_delete    (cell_d[r][SCORE_W-1:0]),
            .o_align          (align),
            .o_insert         (insert),
            .o_delete         (delete),
            .o_score          (score),
            .o_ref_base_valid (base_valid[r+1]),
            .o_ref_base       (base[r+1])
        );

        assign cell_c[r] = {align, insert, delete};
        assign o_row_scores[r*SCORE_W +: SCORE_W] = score;
    end

endmodule

/* sw_ctrl_fsm.sv */
`timescale 1ns/100ps
// alignment job controller
module sw_ctrl_fsm import sw_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    input  logic i_ready,
    input  logic i_calc_last,
    input  logic i_scan_last,
    output logic o_ready,
    output logic o_valid,
    output logic o_load,
    output logic o_calc_en,
    output logic o_scan_en
);
    sw_state_t state;
    sw_state_t state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (i_valid) state_nxt = LOAD;
            LOAD: state_nxt = CALC;              // job latched, array settles
            CALC: if (i_calc_last) state_nxt = SCAN;
            SCAN: if (i_scan_last) state_nxt = DONE;
            DONE: if (i_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign o_ready   = (state == IDLE);
    assign o_load    = o_ready && i_valid;  // accepting edge
    assign o_calc_en = (state == CALC);
    assign o_scan_en = (state == SCAN);
    assign o_valid   = (state == DONE);

endmodule

/* sw_step_counter.sv */
`timescale 1ns/100ps
// calc and scan step counter
module sw_step_counter import sw_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_load,
    input  logic                  i_calc_en,
    input  logic                  i_scan_en,
    input  logic [REF_LEN_W-1:0]  i_ref_len,
    input  logic [READ_LEN_W-1:0] i_read_len,
    output logic [STEP_W-1:0]     o_step,
    output logic                  o_ref_base_valid,
    output logic                  o_calc_last,
    output logic                  o_scan_last,
    output logic [READ_LEN_W-1:0] o_read_len
);
    logic [REF_LEN_W-1:0] ref_len;
    logic [STEP_W-1:0]    calc_end;
    logic [STEP_W-1:0]    scan_end;

    assign calc_end = STEP_W'(ref_len) + STEP_W'(o_read_len) - STEP_W'(1);
    assign scan_end = STEP_W'(o_read_len) - STEP_W'(1);

    assign o_ref_base_valid = i_calc_en && (o_step < STEP_W'(ref_len));
    assign o_calc_last      = i_calc_en && (o_step == calc_end);
    assign o_scan_last      = i_scan_en && (o_step == scan_end);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_step     <= '0;
            ref_len    <= '0;
            o_read_len <= '0;
        end else if (i_load) begin
            o_step     <= '0;
            ref_len    <= i_ref_len;
            o_read_len <= i_read_len;
        end else if (o_calc_last || o_scan_last) begin
            o_step <= '0;  // restart for next phase
        end else if (i_calc_en || i_scan_en) begin
            o_step <= o_step + STEP_W'(1);
        end
    end

endmodule

/* sw_max_tracker.sv */
`timescale 1ns/100ps
// best score tracker
module sw_max_tracker import sw_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_load,
    input  logic                            i_calc_en,
    input  logic                            i_scan_en,
    input  logic [STEP_W-1:0]               i_step,
    input  logic [READ_LEN_W-1:0]           i_read_len,
    input  logic [READ_MAX_LEN*SCORE_W-1:0] i_row_scores,
    output logic signed [SCORE_W-1:0]       o_score,
    output logic [ROW_W-1:0]                o_row,
    output logic [COL_W-1:0]                o_col
);
    logic signed [SCORE_W-1:0] row_best [READ_MAX_LEN];
    logic [COL_W-1:0]          row_col  [READ_MAX_LEN];
    logic [ROW_W-1:0]          scan_row;

    assign scan_row = i_step[ROW_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_best <= '{default: '0};
            row_col  <= '{default: '0};
            o_score  <= '0;
            o_row    <= '0;
            o_col    <= '0;
        end else if (i_load) begin
            row_best <= '{default: '0};
            row_col  <= '{default: '0};
            o_score  <= '0;
            o_row    <= '0;
            o_col    <= '0;
        end else if (i_calc_en) begin
            for (int r = 0; r < READ_MAX_LEN; r++) begin
                // strictly greater keeps the first column
                if ($signed(i_row_scores[r*SCORE_W +: SCORE_W]) > row_best[r]) begin
                    row_best[r] <= $signed(i_row_scores[r*SCORE_W +: SCORE_W]);
                    row_col[r]  <= COL_W'(i_step - STEP_W'(r + 1));
                end
            end
        end else if (i_scan_en) begin
            if ((i_step < STEP_W'(i_read_len)) && (row_best[scan_row] > o_score)) begin
                o_score <= row_best[scan_row];
                o_row   <= scan_row;
                o_col   <= row_col[scan_row];
            end
        end
    end

endmodule

/* sw_top.sv */
`timescale 1ns/100ps
// smith-waterman alignment core
module sw_top import sw_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_valid,
    input  logic [2*REF_MAX_LEN-1:0]  i_seq_ref,
    input  logic [2*READ_MAX_LEN-1:0] i_seq_read,
    input  logic [REF_LEN_W-1:0]      i_ref_len,
    input  logic [READ_LEN_W-1:0]     i_read_len,
    output logic                      o_ready,
    output logic                      o_valid,
    output logic signed [SCORE_W-1:0] o_score,
    output logic [ROW_W-1:0]          o_row,
    output logic [COL_W-1:0]          o_col,
    input  logic                      i_ready
);
    logic                            load;
    logic                            calc_en;
    logic                            scan_en;
    logic                            calc_last;
    logic                            scan_last;
    logic                            ref_base_valid;
    logic [STEP_W-1:0]               step;
    logic [READ_LEN_W-1:0]           read_len;
    logic [READ_MAX_LEN*SCORE_W-1:0] row_scores;

    sw_ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_ready     (i_ready),
        .i_calc_last (calc_last),
        .i_scan_last (scan_last),
        .o_ready     (o_ready),
        .o_valid     (o_valid),
        .o_load      (load),
        .o_calc_en   (calc_en),
        .o_scan_en   (scan_en)
    );

    sw_step_counter u_step_counter (
        .clk              (clk),
        .rst              (rst),
        .i_load           (load),
        .i_calc_en        (calc_en),
        .i_scan_en        (scan_en),
        .i_ref_len        (i_ref_len),
        .i_read_len       (i_read_len),
        .o_step           (step),
        .o_ref_base_valid (ref_base_valid),
        .o_calc_last      (calc_last),
        .o_scan_last      (scan_last),
        .o_read_len       (read_len)
    );

    sw_pe_array u_pe_array (
        .clk              (clk),
        .rst              (rst),
        .i_load           (load),
        .i_calc_en        (calc_en),
        .i_seq_ref        (i_seq_ref),
        .i_seq_read       (i_seq_read),
        .i_ref_base_valid (ref_base_valid),
        .o_row_scores     (row_scores)
    );

    sw_max_tracker u_max_tracker (
        .clk          (clk),
        .rst          (rst),
        .i_load       (load),
        .i_calc_en    (calc_en),
        .i_scan_en    (scan_en),
        .i_step       (step),
        .i_read_len   (read_len),
        .i_row_scores (row_scores),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_col        (o_col)
    );

endmodule

/* tb_sw_top.sv */
`timescale 1ns/100ps
// alignment core testbench
module tb_sw_top import sw_pkg::*; ();

    logic                      clk;
    logic                      rst;
    logic                      i_valid;
    logic [2*REF_MAX_LEN-1:0]  i_seq_ref;
    logic [2*READ_MAX_LEN-1:0] i_seq_read;
    logic [REF_LEN_W-1:0]      i_ref_len;
    logic [READ_LEN_W-1:0]     i_read_len;
    logic                      o_ready;
    logic                      o_valid;
    logic signed [SCORE_W-1:0] o_score;
    logic [ROW_W-1:0]          o_row;
    logic [COL_W-1:0]          o_col;
    logic                      i_ready;

    integer      seed;
    integer      fd;
    integer      fields;
    int          job_count;
    string       line;
    logic [31:0] stim [8];  // one stimulus line

    sw_top u_sw_top (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_col      (o_col),
        .i_ready    (i_ready)
    );

    always begin
        #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_result(input logic [31:0] exp_score, input logic [31:0] exp_row,
                                input logic [31:0] exp_col);
        check_value("o_score", 32'(o_score), exp_score);
        check_value("o_row", 32'(o_row), exp_row);
        check_value("o_col", 32'(o_col), exp_col);
    endtask

    // offer one job, wait for its result, then release it
    task automatic run_job(input int ref_len, input int read_len, input logic [31:0] seq_ref,
                           input logic [31:0] seq_read, input logic [31:0] exp_score,
                           input logic [31:0] exp_row, input logic [31:0] exp_col,
                           input logic hold_ready);
        int waited;
        int cycles;
        int hold;
        i_seq_ref  = seq_ref;
        i_seq_read = seq_read[2*READ_MAX_LEN-1:0];
        i_ref_len  = REF_LEN_W'(ref_len);
        i_read_len = READ_LEN_W'(read_len);
        i_valid    = 1'b1;
        waited     = 0;
        while (o_ready !== 1'b1) begin
            if (waited == 4) begin
                abort_run("timeout waiting for o_ready before offering a job");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);  // job taken on the edge just passed
        i_valid = 1'b0;
        cycles  = 1;
        check_value("o_ready", 32'(o_ready), 0);
        while (o_valid !== 1'b1) begin
            if (cycles > ref_len + 2 * read_len + 8) begin
                abort_run("timeout waiting for o_valid after a job was accepted");
            end
            @(negedge clk);
            cycles++;
        end
        check_value("o_valid latency", cycles, ref_len + 2 * read_len + 2);
        check_result(exp_score, exp_row, exp_col);

        hold = hold_ready ? int'($unsigned($random(seed)) % 8) : 0;
        repeat (hold) begin
            i_valid   = 1'b1;  // a new job must wait
            i_seq_ref = $random(seed);
            @(negedge clk);
            check_value("o_valid", 32'(o_valid), 1);
            check_value("o_ready", 32'(o_ready), 0);
            check_result(exp_score, exp_row, exp_col);
        end
        i_valid = 1'b0;
        i_ready = 1'b1;
        @(negedge clk);
        i_ready = 1'b0;
        check_value("o_valid", 32'(o_valid), 0);
        check_value("o_ready", 32'(o_ready), 1);
    endtask

    initial begin
        seed        = 32'h8ebb_6188;
        job_count   = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        i_valid     = 1'b0;
        i_ready     = 1'b0;
        i_seq_ref   = '0;
        i_seq_read  = '0;
        i_ref_len   = '0;
        i_read_len  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("o_ready", 32'(o_ready), 1);
        check_value("o_valid", 32'(o_valid), 0);
        check_result(0, 0, 0);

        fd = $fopen("sw_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sw_stim.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h", stim[0], stim[1],
                                 stim[2], stim[3], stim[4], stim[5], stim[6], stim[7]);
                if (fields == 8) begin
                    run_job(stim[0], stim[1], stim[2], stim[3], stim[4], stim[5], stim[6],
                            stim[7][0]);
                    job_count++;
                end else if (fields > 0) begin
                    abort_run("malformed job line in sw_stim.txt");
                end
            end
        end
        $fclose(fd);

        if (job_count == 0) begin
            abort_run("no jobs found in sw_stim.txt");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* sw_stim.txt */
# ref_len read_len ref_seq read_seq score row col hold_ready (all hex)
# sequences packed first base in the top bits, A=0 C=1 G=2 T=3
08 04 F1BF0000 1B00 08 3 5 0
06 04 58D00000 8D00 08 3 5 1
10 08 AAAA1BE4 1BE4 10 7 F 0
10 08 1BE4AAAA 1BE4 10 7 7 1
08 04 00000000 5500 00 0 0 1
08 02 E0000000 E000 04 1 1 0
05 05 1B000000 1F00 07 4 4 0
08 07 1B1B0000 186C 0C 6 7 1
08 06 1BC60000 1860 09 5 7 0
06 07 18600000 1B18 0A 6 5 1
02 06 A0000000 AFA0 04 1 1 1
05 02 1C400000 1000 04 1 1 0
01 01 C0000000 C000 02 0 0 1

/* sw_top.f */
sw_pkg.sv
sw_pe.sv
sw_pe_array.sv
sw_ctrl_fsm.sv
sw_step_counter.sv
sw_max_tracker.sv
sw_top.sv
tb_sw_top.sv

/* Bender.yml */
package:
  name: sw_align

sources:
  - sw_pkg.sv
  - sw_pe.sv
  - sw_pe_array.sv
  - sw_ctrl_fsm.sv
  - sw_step_counter.sv
  - sw_max_tracker.sv
  - sw_top.sv
  - target: test
    files:
      - tb_sw_top.sv
